// File: common/DrivePkg.sv
// Drive phases and 1/3 bias levels
package DrivePkg;

	// Voltage level in thirds of the supply
	typedef logic [1:0] levelT;

	// Indexed by pin number, 1 to 36
	typedef levelT [PanelPkg::PinCount:1] pinLevelsT;

	typedef enum logic {
		HighHalf = 1'b0,
		LowHalf = 1'b1
	} halfT;

	typedef struct packed {
		halfT half;
		logic [1:0] com;
	} phaseT;

	// Each pin swaps to the mirrored level in the low half for DC balance
	localparam levelT ComHighActive = 2'd3;
	localparam levelT ComHighPassive = 2'd1;
	localparam levelT SegHighActive = 2'd0;
	localparam levelT SegHighPassive = 2'd2;
	localparam levelT ComLowActive = 2'd0;
	localparam levelT ComLowPassive = 2'd2;
	localparam levelT SegLowActive = 2'd3;
	localparam levelT SegLowPassive = 2'd1;

	// Clocks per PWM period
	localparam int PwmSteps = 3;

	function automatic levelT comLevel(input halfT half, input logic active);
		if (half == HighHalf) begin
			return active ? ComHighActive : ComHighPassive;
		end
		return active ? ComLowActive : ComLowPassive;
	endfunction

	function automatic levelT segLevel(input halfT half, input logic active);
		if (half == HighHalf) begin
			return active ? SegHighActive : SegHighPassive;
		end
		return active ? SegLowActive : SegLowPassive;
	endfunction

endpackage

// File: common/PanelPkg.sv
// Panel geometry and pin numbering
package PanelPkg;

	// Eight 14-segment characters on 4 commons and 32 segment lines
	localparam int CharCount = 8;
	localparam int ComCount = 4;
	localparam int PinCount = 36;

	// One character, segments a to n plus the decimal point
	typedef struct packed {
		logic dp;
		logic n;
		logic m;
		logic l;
		logic k;
		logic j;
		logic i;
		logic h;
		logic g;
		logic f;
		logic e;
		logic d;
		logic c;
		logic b;
		logic a;
	} glyphT;

	// Character 0 is the rightmost one
	typedef glyphT [CharCount-1:0] panelT;

	typedef logic [5:0] pinIndexT;

	// Commons 0 to 3 sit on pins 1 to 4
	localparam pinIndexT ComPin [ComCount] = '{6'd1, 6'd2, 6'd3, 6'd4};

	localparam pinIndexT FirstSegPin = 6'd5;

	// Role of each of the four segment pins of a character
	typedef enum logic [1:0] {
		SegAbcp = 2'd0,
		SegFed = 2'd1,
		SegIjkn = 2'd2,
		SegHglm = 2'd3
	} segRoleT;

	// Pin number of one segment line of character charIndex
	function automatic pinIndexT segPin(
		input int charIndex,
		input segRoleT role
	);
		int pin;
		pin = int'(FirstSegPin) + 4 * charIndex + int'(role);
		return pinIndexT'(pin);
	endfunction

endpackage

// File: logic/BiasModulator.sv
// 1/3 bias PWM modulator
module BiasModulator (
	input logic Clock,
	input logic Reset,
	input DrivePkg::pinLevelsT Levels_i,
	output logic [PanelPkg::PinCount:1] Pin_o
);

	localparam int CountWidth = $clog2(DrivePkg::PwmSteps);
	localparam int LevelCount = 2 ** $bits(DrivePkg::levelT);
	localparam logic [CountWidth-1:0] LastStep = CountWidth'(DrivePkg::PwmSteps - 1);

	logic [CountWidth-1:0] step;
	logic [LevelCount-1:0] wave;

	// Modulo PwmSteps counter
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			step <= '0;
		end else if (step == LastStep) begin
			step <= '0;
		end else begin
			step <= step + 1'b1;
		end
	end

	// Level L is high for the first L steps of each period
	always_comb begin
		for (int l = 0; l < LevelCount; l++) begin
			wave[l] = (step < l);
		end
	end

	// Each pin picks the waveform of its level
	always_comb begin
		for (int p = 1; p <= PanelPkg::PinCount; p++) begin
			Pin_o[p] = wave[Levels_i[p]];
		end
	end

	assert property (@(posedge Clock) disable iff (!Reset)
		step < CountWidth'(DrivePkg::PwmSteps))
		else $error("PWM step counter out of range");

endmodule

// File: logic/PhaseSequencer.sv
// Drive phase sequencer
module PhaseSequencer #(
	parameter int ClockHz = 10_000_000,
	parameter int PhaseUs = 1000
) (
	input logic Clock,
	input logic Reset,
	output DrivePkg::phaseT Phase_o
);

	localparam int PhaseCycles = ClockHz / 1_000_000 * PhaseUs;
	localparam int DividerWidth = (PhaseCycles > 1) ? $clog2(PhaseCycles) : 1;
	localparam logic [1:0] LastCom = 2'(PanelPkg::ComCount - 1);

	logic [DividerWidth-1:0] divider;
	logic strobe;
	DrivePkg::phaseT phase;

	// One-cycle pulse at the end of each phase period
	assign strobe = (divider == DividerWidth'(PhaseCycles - 1));

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			divider <= '0;
		end else if (strobe) begin
			divider <= '0;
		end else begin
			divider <= divider + 1'b1;
		end
	end

	// Commons 0 to 3 in the high half, then again in the low half
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			phase.half <= DrivePkg::HighHalf;
			phase.com <= 2'd0;
		end else if (strobe) begin
			if (phase.com == LastCom) begin
				if (phase.half == DrivePkg::HighHalf) begin
					phase.half <= DrivePkg::LowHalf;
				end else begin
					phase.half <= DrivePkg::HighHalf;
				end
			end
			phase.com <= phase.com + 2'd1;
		end
	end

	assign Phase_o = phase;

	// The divider must restart after every strobe
	assert property (@(posedge Clock) disable iff (!Reset) strobe |=> !strobe)
		else $error("Phase strobe held for more than one cycle");

endmodule

// File: logic/Vim828Driver.sv
// Multiplexed LCD panel driver
module Vim828Driver #(
	parameter int ClockHz = 10_000_000,
	parameter int PhaseUs = 1000
) (
	input logic Clock,
	input logic Reset,
	input PanelPkg::panelT Glyphs_i,
	output logic [PanelPkg::PinCount:1] Pin_o
);

	DrivePkg::phaseT phase;
	DrivePkg::pinLevelsT levels;

	// Eight drive phases per frame
	PhaseSequencer #(
		.ClockHz(ClockHz),
		.PhaseUs(PhaseUs)
	) phaseSequencer (
		.Clock(Clock),
		.Reset(Reset),
		.Phase_o(phase)
	);

	// Level of every pin, one clock behind the phase
	SegmentMapper segmentMapper (
		.Clock(Clock),
		.Reset(Reset),
		.Phase_i(phase),
		.Glyphs_i(Glyphs_i),
		.Levels_o(levels)
	);

	BiasModulator biasModulator (
		.Clock(Clock),
		.Reset(Reset),
		.Levels_i(levels),
		.Pin_o(Pin_o)
	);

endmodule

// File: mapper/SegmentMapper.sv
// Panel segment mapper
module SegmentMapper (
	input logic Clock,
	input logic Reset,
	input DrivePkg::phaseT Phase_i,
	input PanelPkg::panelT Glyphs_i,
	output DrivePkg::pinLevelsT Levels_o
);

	// First phase after reset
	localparam DrivePkg::phaseT ResetPhase = '{half: DrivePkg::HighHalf, com: 2'd0};

	DrivePkg::pinLevelsT levels;

	// Pin levels of one phase for the whole panel
	function automatic DrivePkg::pinLevelsT mapPanel(
		input DrivePkg::phaseT phase,
		input PanelPkg::panelT glyphs
	);
		DrivePkg::pinLevelsT pinLevels;
		PanelPkg::glyphT glyph;
		logic abcp;
		logic fed;
		logic ijkn;
		logic hglm;
		pinLevels = '0;
		for (int c = 0; c < PanelPkg::ComCount; c++) begin
			pinLevels[PanelPkg::ComPin[c]] = DrivePkg::comLevel(phase.half, phase.com == c);
		end
		for (int k = 0; k < PanelPkg::CharCount; k++) begin
			glyph = glyphs[k];
			case (phase.com)
				2'd0: begin
					abcp = glyph.a;
					// FED line has no segment on common 0
					fed = 1'b0;
					ijkn = glyph.i;
					hglm = glyph.h;
				end
				2'd1: begin
					abcp = glyph.b;
					fed = glyph.f;
					ijkn = glyph.j;
					hglm = glyph.g;
				end
				2'd2: begin
					abcp = glyph.c;
					fed = glyph.e;
					ijkn = glyph.k;
					hglm = glyph.l;
				end
				default: begin
					abcp = glyph.dp;
					fed = glyph.d;
					ijkn = glyph.n;
					hglm = glyph.m;
				end
			endcase
			pinLevels[PanelPkg::segPin(k, PanelPkg::SegAbcp)] =
				DrivePkg::segLevel(phase.half, abcp);
			pinLevels[PanelPkg::segPin(k, PanelPkg::SegFed)] =
				DrivePkg::segLevel(phase.half, fed);
			pinLevels[PanelPkg::segPin(k, PanelPkg::SegIjkn)] =
				DrivePkg::segLevel(phase.half, ijkn);
			pinLevels[PanelPkg::segPin(k, PanelPkg::SegHglm)] =
				DrivePkg::segLevel(phase.half, hglm);
		end
		return pinLevels;
	endfunction

	// Commons that sit at the active level of the given half
	function automatic logic [PanelPkg::ComCount-1:0] activeComs(
		input DrivePkg::pinLevelsT pinLevels,
		input DrivePkg::halfT half
	);
		logic [PanelPkg::ComCount-1:0] active;
		for (int c = 0; c < PanelPkg::ComCount; c++) begin
			active[c] = (pinLevels[PanelPkg::ComPin[c]] == DrivePkg::comLevel(half, 1'b1));
		end
		return active;
	endfunction

	// Blank panel pattern of the first phase while in reset
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			levels <= mapPanel(ResetPhase, '0);
		end else begin
			levels <= mapPanel(Phase_i, Glyphs_i);
		end
	end

	assign Levels_o = levels;

	// Levels lag the phase by one clock, so check against the previous half
	assert property (@(posedge Clock) disable iff (!Reset)
		$onehot(activeComs(Levels_o, $past(Phase_i.half))))
		else $error("Common lines do not select exactly one active common");

endmodule

// File: project.f
+incdir+tests
common/PanelPkg.sv
common/DrivePkg.sv
logic/PhaseSequencer.sv
mapper/SegmentMapper.sv
logic/BiasModulator.sv
logic/Vim828Driver.sv
tests/Vim828DriverTb.sv

// File: tests/PanelModel.svh
// Panel reference model and checks
`ifndef PANEL_MODEL_SVH
`define PANEL_MODEL_SVH

// Columns are active common, passive common, active segment, passive segment
localparam DrivePkg::levelT LevelRule [2][4] = '{
	'{2'd3, 2'd1, 2'd0, 2'd2},
	'{2'd0, 2'd2, 2'd3, 2'd1}
};

// Phase order is com 0 to 3 high, then com 0 to 3 low
function automatic DrivePkg::phaseT phaseAt(input int index);
	DrivePkg::phaseT phase;
	phase.com = 2'(index % 4);
	phase.half = ((index / 4) % 2 == 1) ? DrivePkg::LowHalf : DrivePkg::HighHalf;
	return phase;
endfunction

// Row bits are HGLM, IJKN, FED, ABCP
function automatic logic segmentActive(
	input PanelPkg::glyphT glyph,
	input int role,
	input logic [1:0] com
);
	logic [3:0] row;
	case (com)
		2'd0: row = {glyph.h, glyph.i, 1'b0, glyph.a};
		2'd1: row = {glyph.g, glyph.j, glyph.f, glyph.b};
		2'd2: row = {glyph.l, glyph.k, glyph.e, glyph.c};
		default: row = {glyph.m, glyph.n, glyph.d, glyph.dp};
	endcase
	return row[role];
endfunction

function automatic DrivePkg::levelT modelLevel(
	input DrivePkg::phaseT phase,
	input PanelPkg::panelT glyphs,
	input int pin
);
	int column;
	int offset;
	logic active;
	if (pin <= PanelPkg::ComCount) begin
		active = ((pin - 1) == int'(phase.com));
		column = active ? 0 : 1;
	end else begin
		offset = pin - int'(PanelPkg::FirstSegPin);
		active = segmentActive(glyphs[offset / 4], offset % 4, phase.com);
		column = active ? 2 : 3;
	end
	return LevelRule[int'(phase.half)][column];
endfunction

task automatic checkLevel(
	input PanelPkg::pinIndexT pin,
	input DrivePkg::levelT actual,
	input DrivePkg::levelT expected
);
	if (actual !== expected) begin
		stopOnError($sformatf("[FAIL] %0t: pin %0d level %0d, expected %0d",
			$time, pin, actual, expected));
	end
endtask

task automatic checkPhase(input DrivePkg::phaseT actual, input DrivePkg::phaseT expected);
	if (actual !== expected) begin
		stopOnError($sformatf("[FAIL] %0t: phase half %0d com %0d, expected half %0d com %0d",
			$time, actual.half, actual.com, expected.half, expected.com));
	end
endtask

// Active common sits at 3 in the high half and at 0 in the low half
task automatic decodePhase(input DrivePkg::pinLevelsT measured, output DrivePkg::phaseT phase);
	int highCount;
	int lowCount;
	highCount = 0;
	lowCount = 0;
	phase = '0;
	for (int c = 0; c < PanelPkg::ComCount; c++) begin
		if (measured[c + 1] == 2'd3) begin
			highCount++;
			phase.com = 2'(c);
		end else if (measured[c + 1] == 2'd0) begin
			lowCount++;
			phase.com = 2'(c);
		end
	end
	if (highCount == 1 && lowCount == 0) begin
		phase.half = DrivePkg::HighHalf;
	end else if (lowCount == 1 && highCount == 0) begin
		phase.half = DrivePkg::LowHalf;
	end else begin
		stopOnError($sformatf("[FAIL] %0t: common lines show no single active common", $time));
	end
endtask

task automatic checkPanel(
	input DrivePkg::phaseT phase,
	input DrivePkg::pinLevelsT measured,
	input PanelPkg::panelT panel
);
	for (int p = 1; p <= PanelPkg::PinCount; p++) begin
		checkLevel(PanelPkg::pinIndexT'(p), measured[p], modelLevel(phase, panel, p));
	end
endtask

`endif

// File: tests/Vim828DriverTb.sv
// LCD panel driver testbench
module Vim828DriverTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int PhaseClocks = 12;
	localparam int FramePhases = 8;
	localparam int WaitLimit = 100;
	// Start of the level window inside a phase
	localparam int SampleOffset = 5;

	logic Clock;
	logic Reset;
	PanelPkg::panelT glyphs;
	logic [PanelPkg::PinCount:1] pins;
	int cycle;
	int nextPhase;
	int seed;

	Vim828Driver #(
		.ClockHz(1_000_000),
		.PhaseUs(12)
	) uut (
		.Clock(Clock),
		.Reset(Reset),
		.Glyphs_i(glyphs),
		.Pin_o(pins)
	);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	// Clocks since the last reset release
	always @(posedge Clock) begin
		if (!Reset) begin
			cycle <= 0;
		end else begin
			cycle <= cycle + 1;
		end
	end

	task automatic stopOnError(input string line);
		$display("%s", line);
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	`include "PanelModel.svh"

	task automatic resetDut();
		@(posedge Clock);
		Reset <= 1'b0;
		repeat (10) @(posedge Clock);
		Reset <= 1'b1;
		nextPhase = 0;
	endtask

	task automatic applyGlyphs(input PanelPkg::panelT panel);
		@(posedge Clock);
		glyphs <= panel;
	endtask

	task automatic randomizeGlyphs(output PanelPkg::panelT panel);
		logic [127:0] bits;
		for (int w = 0; w < 4; w++) begin
			bits[w * 32 +: 32] = $random(seed);
		end
		panel = bits[$bits(PanelPkg::panelT)-1:0];
	endtask

	task automatic waitForCycle(input int target);
		int waited;
		waited = 0;
		@(negedge Clock);
		while (cycle != target) begin
			if (waited == WaitLimit) begin
				stopOnError($sformatf("Timeout while waiting for clock %0d after reset", target));
			end
			@(negedge Clock);
			waited++;
		end
	endtask

	// Count high samples over one PWM period
	task automatic measureNext(output DrivePkg::phaseT phase, output DrivePkg::pinLevelsT measured);
		phase = phaseAt(nextPhase);
		waitForCycle(nextPhase * PhaseClocks + SampleOffset);
		measured = '0;
		for (int s = 0; s < DrivePkg::PwmSteps; s++) begin
			if (s > 0) begin
				@(negedge Clock);
			end
			for (int p = 1; p <= PanelPkg::PinCount; p++) begin
				measured[p] = measured[p] + DrivePkg::levelT'(pins[p]);
			end
		end
		nextPhase++;
	endtask

	task automatic blankAfterReset();
		DrivePkg::phaseT phase;
		DrivePkg::phaseT seen;
		DrivePkg::pinLevelsT measured;
		DrivePkg::levelT expected;
		measureNext(phase, measured);
		decodePhase(measured, seen);
		checkPhase(seen, phase);
		for (int p = 1; p <= PanelPkg::PinCount; p++) begin
			expected = (p == 1) ? 2'd3 : (p <= 4) ? 2'd1 : 2'd2;
			checkLevel(PanelPkg::pinIndexT'(p), measured[p], expected);
		end
	endtask

	task automatic phaseSequence();
		DrivePkg::phaseT phase;
		DrivePkg::phaseT seen;
		DrivePkg::pinLevelsT measured;
		repeat (2 * FramePhases) begin
			measureNext(phase, measured);
			decodePhase(measured, seen);
			checkPhase(seen, phase);
		end
	endtask

	task automatic segmentMapping();
		PanelPkg::panelT panel;
		DrivePkg::phaseT phase;
		DrivePkg::pinLevelsT measured;
		randomizeGlyphs(panel);
		applyGlyphs(panel);
		repeat (FramePhases) begin
			measureNext(phase, measured);
			checkPanel(phase, measured, panel);
		end
		// The FED line on common 0 stays passive even with every segment lit
		panel = '1;
		applyGlyphs(panel);
		repeat (FramePhases) begin
			measureNext(phase, measured);
			checkPanel(phase, measured, panel);
		end
	endtask

	task automatic dcBalance();
		PanelPkg::panelT panel;
		DrivePkg::phaseT phase;
		DrivePkg::pinLevelsT measured;
		DrivePkg::pinLevelsT frame [FramePhases];
		int sum;
		randomizeGlyphs(panel);
		applyGlyphs(panel);
		repeat (FramePhases) begin
			measureNext(phase, measured);
			frame[int'(phase)] = measured;
		end
		for (int com = 0; com < PanelPkg::ComCount; com++) begin
			for (int p = 1; p <= PanelPkg::PinCount; p++) begin
				sum = int'(frame[com][p]) + int'(frame[com + 4][p]);
				checkLevel(PanelPkg::pinIndexT'(p), DrivePkg::levelT'(sum), 2'd3);
			end
		end
	endtask

	task automatic glyphUpdate();
		PanelPkg::panelT oldPanel;
		PanelPkg::panelT newPanel;
		DrivePkg::phaseT phase;
		DrivePkg::pinLevelsT measured;
		randomizeGlyphs(oldPanel);
		applyGlyphs(oldPanel);
		measureNext(phase, measured);
		checkPanel(phase, measured, oldPanel);
		// Changed in the middle of the phase just measured
		newPanel = ~oldPanel;
		applyGlyphs(newPanel);
		measureNext(phase, measured);
		checkPanel(phase, measured, newPanel);
	endtask

	task automatic midFrameReset();
		DrivePkg::phaseT phase;
		DrivePkg::phaseT seen;
		DrivePkg::phaseT upcoming;
		DrivePkg::pinLevelsT measured;
		upcoming = phaseAt(nextPhase);
		while (upcoming.half != DrivePkg::LowHalf) begin
			nextPhase++;
			upcoming = phaseAt(nextPhase);
		end
		measureNext(phase, measured);
		decodePhase(measured, seen);
		checkPhase(seen, phase);
		resetDut();
		measureNext(phase, measured);
		decodePhase(measured, seen);
		checkPhase(seen, phaseAt(0));
		checkPanel(phase, measured, glyphs);
	endtask

	initial begin
		seed = 32'hf3bb_61dc;
		Reset = 1'b0;
		glyphs = '0;
		nextPhase = 0;
		resetDut();
		blankAfterReset();
		phaseSequence();
		segmentMapping();
		dcBalance();
		glyphUpdate();
		midFrameReset();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule
